// File: riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// data path and pc width, one RV64 word
`define XLEN 64

`define INST_W 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// File: riscv_pkg.sv
package riscv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0, // zero so a bubble decodes to add
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_BEQ  = 3'd1,
    BR_BNE  = 3'd2,
    BR_BLT  = 3'd3,
    BR_BGE  = 3'd4,
    BR_JUMP = 3'd5 // jal, always taken
  } branch_e;

  typedef enum logic [1:0] {
    OPA_RS1  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } opa_sel_e;

  // execute control, all zero is a bubble
  typedef struct packed {
    alu_op_e  alu_op;
    opa_sel_e opa_sel;
    logic     b_imm;   // immediate in place of rs2
    branch_e  branch;
    logic     regw;
    logic     link;    // result is pc+4
  } ex_ctrl_t;

endpackage

// File: riscv_if.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

// decode/execute register contents
interface de_if;
  import riscv_pkg::*;

  logic [`XLEN-1:0]       pc;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       imm;
  logic [`REG_ADDR_W-1:0] rd;
  ex_ctrl_t               ctrl;

  modport decode (
    output pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd, ctrl
  );

  modport execute (
    input pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd, ctrl
  );
endinterface

// memory and writeback stage state, shared by forwarding and the register file
interface fwd_if;
  logic                   regw_m;
  logic [`REG_ADDR_W-1:0] rd_m;
  logic [`XLEN-1:0]       result_m;
  logic                   regw_w;
  logic [`REG_ADDR_W-1:0] rd_w;
  logic [`XLEN-1:0]       data_w;

  modport retire (
    output regw_m, rd_m, result_m, regw_w, rd_w, data_w
  );

  modport execute (
    input regw_m, rd_m, result_m, regw_w, rd_w, data_w
  );

  // register file write port only
  modport regfile (
    input regw_w, rd_w, data_w
  );
endinterface

// File: riscv_fetch.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_fetch (
  input  logic               i_riscv_core_clk,
  input  logic               i_rst_n,
  input  logic               i_redirect,
  input  logic [`XLEN-1:0]   i_target,
  input  logic [`INST_W-1:0] i_inst,
  output logic [`XLEN-1:0]   o_pc,
  output logic [`XLEN-1:0]   o_pc_d,
  output logic [`INST_W-1:0] o_inst_d
);

  logic [`XLEN-1:0] pc_next;

  // taken branch or jump from execute wins over sequential fetch
  assign pc_next = i_redirect ? i_target : o_pc + `XLEN'd4;

  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      o_pc <= `RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

  // fetch/decode register
  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      o_inst_d <= `NOP_INST;
    end else if (i_redirect) begin
      o_inst_d <= `NOP_INST; // squash the wrong-path fetch
    end else begin
      o_inst_d <= i_inst;
    end
  end

  always_ff @(posedge i_riscv_core_clk) begin
    o_pc_d <= o_pc;
  end

endmodule

// File: riscv_decode.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_decode (
  input  logic               i_riscv_core_clk,
  input  logic               i_rst_n,
  input  logic               i_flush,
  input  logic [`XLEN-1:0]   i_pc_d,
  input  logic [`INST_W-1:0] i_inst_d,
  de_if.decode               de,
  fwd_if.regfile             fwd
);
  import riscv_pkg::*;

  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  opcode_e                opcode;
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_u;
  logic [`XLEN-1:0]       imm_b;
  logic [`XLEN-1:0]       imm_j;
  logic [`XLEN-1:0]       imm;
  ex_ctrl_t               ctrl;
  logic [`XLEN-1:0]       regs [`NUM_REGS];

  assign opcode   = opcode_e'(i_inst_d[6:0]);
  assign rd_addr  = i_inst_d[11:7];
  assign funct3   = i_inst_d[14:12];
  assign rs1_addr = i_inst_d[19:15];
  assign rs2_addr = i_inst_d[24:20];
  assign funct7   = i_inst_d[31:25];

  assign imm_i = {{(`XLEN-12){i_inst_d[31]}}, i_inst_d[31:20]};
  assign imm_u = {{(`XLEN-32){i_inst_d[31]}}, i_inst_d[31:12], 12'b0};
  assign imm_b = {{(`XLEN-13){i_inst_d[31]}}, i_inst_d[31], i_inst_d[7],
                  i_inst_d[30:25], i_inst_d[11:8], 1'b0};
  assign imm_j = {{(`XLEN-21){i_inst_d[31]}}, i_inst_d[31], i_inst_d[19:12],
                  i_inst_d[20], i_inst_d[30:21], 1'b0};

  always_comb begin
    ctrl = '0;
    imm  = imm_i;
    case (opcode)
      OPC_OP: begin
        // funct7 0x20 only for sub and sra
        if (funct7 == 7'b0 || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl.regw = 1'b1;
          case (funct3)
            3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
            3'b001:  ctrl.alu_op = ALU_SLL;
            3'b010:  ctrl.alu_op = ALU_SLT;
            3'b011:  ctrl.alu_op = ALU_SLTU;
            3'b100:  ctrl.alu_op = ALU_XOR;
            3'b101:  ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  ctrl.alu_op = ALU_OR;
            default: ctrl.alu_op = ALU_AND;
          endcase
        end
      end
      OPC_OP_IMM: begin
        ctrl.b_imm = 1'b1;
        ctrl.regw  = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_ADD;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b111:  ctrl.alu_op = ALU_AND;
          default: ctrl = '0; // shifts and sltiu not in the subset
        endcase
      end
      OPC_LUI: begin
        ctrl.opa_sel = OPA_ZERO;
        ctrl.b_imm   = 1'b1;
        ctrl.regw    = 1'b1;
        imm          = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.opa_sel = OPA_PC;
        ctrl.b_imm   = 1'b1;
        ctrl.regw    = 1'b1;
        imm          = imm_u;
      end
      OPC_JAL: begin
        ctrl.branch = BR_JUMP;
        ctrl.link   = 1'b1;
        ctrl.regw   = 1'b1;
        imm         = imm_j;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'b000:  ctrl.branch = BR_BEQ;
          3'b001:  ctrl.branch = BR_BNE;
          3'b100:  ctrl.branch = BR_BLT;
          3'b101:  ctrl.branch = BR_BGE;
          default: ctrl.branch = BR_NONE;
        endcase
      end
      default: ctrl = '0; // unknown opcode becomes a bubble
    endcase
    if (rd_addr == '0) begin
      ctrl.regw = 1'b0; // x0 is never written
    end
  end

  // x0 reads zero, a same-cycle writeback is seen first
  function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (fwd.regw_w && fwd.rd_w == addr) begin
      val = fwd.data_w;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (fwd.regw_w) begin
      regs[fwd.rd_w] <= fwd.data_w;
    end
  end

  // decode/execute register
  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n || i_flush) begin
      de.ctrl <= '0;
    end else begin
      de.ctrl <= ctrl;
    end
  end

  always_ff @(posedge i_riscv_core_clk) begin
    de.pc       <= i_pc_d;
    de.rs1_addr <= rs1_addr;
    de.rs2_addr <= rs2_addr;
    de.rs1_data <= read_reg(rs1_addr);
    de.rs2_data <= read_reg(rs2_addr);
    de.imm      <= imm;
    de.rd       <= rd_addr;
  end

endmodule

// File: riscv_execute.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_execute (
  de_if.execute                  de,
  fwd_if.execute                 fwd,
  output logic                   o_redirect,
  output logic [`XLEN-1:0]       o_target,
  output logic                   o_regw,
  output logic [`REG_ADDR_W-1:0] o_rd,
  output logic [`XLEN-1:0]       o_result
);
  import riscv_pkg::*;

  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [5:0]       shamt;
  logic [`XLEN-1:0] alu_res;
  logic             src_eq;
  logic             src_lt;
  logic             taken;

  // memory stage is younger, so it has priority over writeback
  function automatic logic [`XLEN-1:0] pick_src(input logic [`REG_ADDR_W-1:0] addr,
                                                input logic [`XLEN-1:0] rf_val);
    logic [`XLEN-1:0] val;
    if (fwd.regw_m && fwd.rd_m == addr) begin
      val = fwd.result_m;
    end else if (fwd.regw_w && fwd.rd_w == addr) begin
      val = fwd.data_w;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  assign src1 = pick_src(de.rs1_addr, de.rs1_data);
  assign src2 = pick_src(de.rs2_addr, de.rs2_data);

  always_comb begin
    case (de.ctrl.opa_sel)
      OPA_PC:   op_a = de.pc;
      OPA_ZERO: op_a = '0; // lui
      default:  op_a = src1;
    endcase
  end

  assign op_b  = de.ctrl.b_imm ? de.imm : src2;
  assign shamt = op_b[5:0]; // rv64 shifts use six bits

  always_comb begin
    case (de.ctrl.alu_op)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
      default:  alu_res = op_a + op_b;
    endcase
  end

  // branch compare uses the forwarded sources rather than the alu operands
  assign src_eq = (src1 == src2);
  assign src_lt = ($signed(src1) < $signed(src2));

  always_comb begin
    case (de.ctrl.branch)
      BR_BEQ:  taken = src_eq;
      BR_BNE:  taken = !src_eq;
      BR_BLT:  taken = src_lt;
      BR_BGE:  taken = !src_lt;
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign o_redirect = taken;
  assign o_target   = de.pc + de.imm;

  assign o_regw   = de.ctrl.regw;
  assign o_rd     = de.rd;
  assign o_result = de.ctrl.link ? de.pc + `XLEN'd4 : alu_res; // jal link value

endmodule

// File: riscv_writeback.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_writeback (
  input  logic                   i_riscv_core_clk,
  input  logic                   i_rst_n,
  input  logic                   i_regw,
  input  logic [`REG_ADDR_W-1:0] i_rd,
  input  logic [`XLEN-1:0]       i_result,
  fwd_if.retire                  fwd
);

  // execute/memory register, no data memory so the result passes through
  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      fwd.regw_m <= 1'b0;
    end else begin
      fwd.regw_m <= i_regw;
    end
  end

  always_ff @(posedge i_riscv_core_clk) begin
    fwd.rd_m     <= i_rd;
    fwd.result_m <= i_result;
  end

  // memory/writeback register, drives the register file and retire port
  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      fwd.regw_w <= 1'b0;
    end else begin
      fwd.regw_w <= fwd.regw_m;
    end
  end

  always_ff @(posedge i_riscv_core_clk) begin
    fwd.rd_w   <= fwd.rd_m;
    fwd.data_w <= fwd.result_m; // alu result or pc+4, chosen in execute
  end

endmodule

// File: riscv_core.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_core (
  input  logic                   i_riscv_core_clk,
  input  logic                   i_rst_n,
  input  logic [`INST_W-1:0]     i_inst,     // from instruction memory, same cycle
  output logic [`XLEN-1:0]       o_pc,
  output logic                   o_wb_valid,
  output logic [`REG_ADDR_W-1:0] o_wb_rd,
  output logic [`XLEN-1:0]       o_wb_data
);

  logic                   redirect;
  logic [`XLEN-1:0]       target;
  logic [`XLEN-1:0]       pc_d;
  logic [`INST_W-1:0]     inst_d;
  logic                   ex_regw;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic [`XLEN-1:0]       ex_result;

  de_if  u_de_if ();
  fwd_if u_fwd_if ();

  riscv_fetch u_riscv_fetch (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_redirect       (redirect),
    .i_target         (target),
    .i_inst           (i_inst),
    .o_pc             (o_pc),
    .o_pc_d           (pc_d),
    .o_inst_d         (inst_d)
  );

  riscv_decode u_riscv_decode (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_flush          (redirect),  // squash the instruction behind a taken branch
    .i_pc_d           (pc_d),
    .i_inst_d         (inst_d),
    .de               (u_de_if.decode),
    .fwd              (u_fwd_if.regfile)
  );

  riscv_execute u_riscv_execute (
    .de               (u_de_if.execute),
    .fwd              (u_fwd_if.execute),
    .o_redirect       (redirect),
    .o_target         (target),
    .o_regw           (ex_regw),
    .o_rd             (ex_rd),
    .o_result         (ex_result)
  );

  riscv_writeback u_riscv_writeback (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_regw           (ex_regw),
    .i_rd             (ex_rd),
    .i_result         (ex_result),
    .fwd              (u_fwd_if.retire)
  );

  // retire port is the register file write
  assign o_wb_valid = u_fwd_if.regw_w;
  assign o_wb_rd    = u_fwd_if.rd_w;
  assign o_wb_data  = u_fwd_if.data_w;

endmodule

// File: riscv_core_checker.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_core_checker (
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic [`XLEN-1:0]       i_pc,
  input logic                   i_wb_valid,
  input logic [`REG_ADDR_W-1:0] i_wb_rd
);

  // pipeline comes out of reset empty
  a_no_retire_in_reset : assert property (
    @(posedge i_clk) !i_rst_n |=> !i_wb_valid
  ) else $error("retire valid while the core is held in reset");

  // x0 writes are dropped in decode
  a_retire_rd_nonzero : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_wb_valid |-> (i_wb_rd != '0)
  ) else $error("retire port shows a write to x0");

  a_pc_aligned : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_pc[1:0] == 2'b00
  ) else $error("fetch pc %h is not word aligned", i_pc);

endmodule

bind riscv_core riscv_core_checker u_riscv_core_checker (
  .i_clk      (i_riscv_core_clk),
  .i_rst_n    (i_rst_n),
  .i_pc       (o_pc),
  .i_wb_valid (o_wb_valid),
  .i_wb_rd    (o_wb_rd)
);

// File: tb_riscv_core.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module tb_riscv_core;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int PROG_LEN       = 64;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * 3 + 40;
  localparam logic [`XLEN-1:0] PROG_BYTES = `XLEN'(PROG_LEN * 4);

  // instruction kinds of the generated program
  localparam int K_R     = 0;
  localparam int K_I     = 1;
  localparam int K_LUI   = 2;
  localparam int K_AUIPC = 3;
  localparam int K_JAL   = 4;
  localparam int K_BR    = 5;

  logic                   clk;
  logic                   i_rst_n = 1'b0;
  logic [`INST_W-1:0]     i_inst;
  logic [`XLEN-1:0]       o_pc;
  logic                   o_wb_valid;
  logic [`REG_ADDR_W-1:0] o_wb_rd;
  logic [`XLEN-1:0]       o_wb_data;

  logic [`INST_W-1:0]     prog [PROG_LEN];
  int                     kind_f [PROG_LEN];
  logic [2:0]             f3_f [PROG_LEN];
  logic                   alt_f [PROG_LEN];  // funct7 bit 5 for sub and sra
  logic [`REG_ADDR_W-1:0] rd_f [PROG_LEN];
  logic [`REG_ADDR_W-1:0] rs1_f [PROG_LEN];
  logic [`REG_ADDR_W-1:0] rs2_f [PROG_LEN];
  logic [`XLEN-1:0]       imm_f [PROG_LEN];
  logic [`REG_ADDR_W-1:0] exp_rd [$];
  logic [`XLEN-1:0]       exp_data [$];
  logic [31:0]            lfsr_state = 32'd95;
  int                     retired = 0;
  int                     mismatch_errs = 0;
  int                     extra_errs = 0;
  int                     pc_errs = 0;
  int                     rst_cycles = 0;
  bit                     timed_out = 1'b0;

  riscv_core DUT (
    .i_riscv_core_clk (clk),
    .i_rst_n          (i_rst_n),
    .i_inst           (i_inst),
    .o_pc             (o_pc),
    .o_wb_valid       (o_wb_valid),
    .o_wb_rd          (o_wb_rd),
    .o_wb_data        (o_wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_cycles < RESET_CYCLES) begin
      rst_cycles <= rst_cycles + 1;
    end
    if (rst_cycles == RESET_CYCLES - 1) begin
      i_rst_n <= 1'b1;
    end
  end

  // instruction memory, answers in the same cycle
  always_comb begin
    if (o_pc < PROG_BYTES) begin
      i_inst = prog[o_pc[7:2]];
    end else begin
      i_inst = `NOP_INST; // past the end of the program
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic logic [`INST_W-1:0] encode_inst(input int i);
    logic [`XLEN-1:0]   o;
    logic [`INST_W-1:0] enc;
    o = imm_f[i];
    case (kind_f[i])
      K_R:     enc = {(alt_f[i] ? 7'b0100000 : 7'b0000000), rs2_f[i], rs1_f[i], f3_f[i],
                      rd_f[i], 7'b0110011};
      K_I:     enc = {o[11:0], rs1_f[i], f3_f[i], rd_f[i], 7'b0010011};
      K_LUI:   enc = {o[31:12], rd_f[i], 7'b0110111};
      K_AUIPC: enc = {o[31:12], rd_f[i], 7'b0010111};
      K_JAL:   enc = {o[20], o[10:1], o[11], o[19:12], rd_f[i], 7'b1101111};
      default: enc = {o[12], o[10:5], rs2_f[i], rs1_f[i], f3_f[i], o[4:1], o[11], 7'b1100011};
    endcase
    return enc;
  endfunction

  function automatic void build_program();
    logic [31:0] sel;
    logic [19:0] u20;
    logic [11:0] i12;
    for (int i = 0; i < PROG_LEN; i++) begin
      sel = take_bits(4);
      rd_f[i]  = 5'(take_bits(3)); // x0..x7 keeps dependencies dense
      rs1_f[i] = 5'(take_bits(3));
      rs2_f[i] = 5'(take_bits(3));
      f3_f[i]  = 3'd0;
      alt_f[i] = 1'b0;
      imm_f[i] = '0;
      if (sel == 11 && i < PROG_LEN - 8) begin
        kind_f[i] = K_JAL;
        imm_f[i] = 64'((32'd2 + take_bits(3) % 32'd7) * 32'd4); // forward 8..32 bytes
      end else if (sel >= 12 && sel <= 14 && i < PROG_LEN - 8) begin
        kind_f[i] = K_BR;
        case (take_bits(2))
          0:       f3_f[i] = 3'd0;
          1:       f3_f[i] = 3'd1;
          2:       f3_f[i] = 3'd4;
          default: f3_f[i] = 3'd5;
        endcase
        imm_f[i] = 64'((32'd2 + take_bits(3) % 32'd7) * 32'd4);
      end else if (sel == 9 || sel == 10) begin
        kind_f[i] = (sel == 9) ? K_LUI : K_AUIPC;
        u20 = 20'(take_bits(20));
        imm_f[i] = {{32{u20[19]}}, u20, 12'b0};
      end else if (sel >= 5 && sel <= 8) begin
        kind_f[i] = K_I;
        case (take_bits(3) % 32'd5)
          0:       f3_f[i] = 3'd0; // addi
          1:       f3_f[i] = 3'd2; // slti
          2:       f3_f[i] = 3'd4;
          3:       f3_f[i] = 3'd6;
          default: f3_f[i] = 3'd7;
        endcase
        i12 = 12'(take_bits(12));
        imm_f[i] = {{52{i12[11]}}, i12};
      end else begin
        kind_f[i] = K_R;
        case (take_bits(4) % 32'd10)
          0: f3_f[i] = 3'd0;
          1: begin
            f3_f[i]  = 3'd0;
            alt_f[i] = 1'b1; // sub
          end
          2: f3_f[i] = 3'd1;
          3: f3_f[i] = 3'd2;
          4: f3_f[i] = 3'd3;
          5: f3_f[i] = 3'd4;
          6: f3_f[i] = 3'd5;
          7: begin
            f3_f[i]  = 3'd5;
            alt_f[i] = 1'b1; // sra
          end
          8:       f3_f[i] = 3'd6;
          default: f3_f[i] = 3'd7;
        endcase
      end
      prog[i] = encode_inst(i);
    end
  endfunction

  // rv64i integer semantics by funct3
  function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'b0, $signed(a) < $signed(b)};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[5:0];
        end else begin
          r = a >> b[5:0];
        end
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // sequential isa model, records the ordered register writes
  function automatic void run_model();
    logic [`XLEN-1:0] xregs [`NUM_REGS];
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] val;
    int               i;
    int               next;
    bit               wr;
    bit               taken;
    for (int k = 0; k < `NUM_REGS; k++) begin
      xregs[k] = '0;
    end
    i = 0;
    while (i < PROG_LEN) begin
      a     = xregs[rs1_f[i]];
      b     = xregs[rs2_f[i]];
      next  = i + 1;
      wr    = 1'b1;
      val   = '0;
      taken = 1'b0;
      case (kind_f[i])
        K_R:     val = alu_ref(f3_f[i], alt_f[i], a, b);
        K_I:     val = alu_ref(f3_f[i], 1'b0, a, imm_f[i]);
        K_LUI:   val = imm_f[i];
        K_AUIPC: val = 64'(i * 4) + imm_f[i];
        K_JAL: begin
          val  = 64'(i * 4 + 4);
          next = i + int'(imm_f[i][7:2]);
        end
        default: begin
          wr = 1'b0;
          case (f3_f[i])
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            default: taken = !($signed(a) < $signed(b));
          endcase
          if (taken) begin
            next = i + int'(imm_f[i][7:2]);
          end
        end
      endcase
      if (wr && rd_f[i] != 5'd0) begin
        xregs[rd_f[i]] = val;
        exp_rd.push_back(rd_f[i]);
        exp_data.push_back(val);
      end
      i = next;
    end
  endfunction

  task automatic finish_run();
    int missing;
    missing = exp_rd.size() - retired;
    $display("errors: %0d mismatches, %0d unexpected retires, %0d reset pc, %0d missing writes",
             mismatch_errs, extra_errs, pc_errs, missing);
    if (mismatch_errs == 0 && extra_errs == 0 && pc_errs == 0 && missing == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // in-order retire check, sampled away from the clock edge
  always @(negedge clk) begin
    if (i_rst_n && o_wb_valid) begin
      if (retired >= exp_rd.size()) begin
        extra_errs++;
        $display("retire to x%0d with no write left in the model", o_wb_rd);
      end else begin
        if (o_wb_rd !== exp_rd[retired]) begin
          mismatch_errs++;
          $display("Error o_wb_rd: expected %h, got %h (write %0d)",
                   exp_rd[retired], o_wb_rd, retired);
        end
        if (o_wb_data !== exp_data[retired]) begin
          mismatch_errs++;
          $display("Error o_wb_data: expected %h, got %h (write %0d)",
                   exp_data[retired], o_wb_data, retired);
        end
        retired++;
      end
    end
  end

  initial begin
    build_program();
    run_model();
    $display("program of %0d instructions, %0d register writes expected",
             PROG_LEN, exp_rd.size());
    @(posedge i_rst_n);
    @(negedge clk);
    if (o_pc !== `RESET_PC) begin
      pc_errs++;
      $display("Error o_pc: expected %h, got %h after reset", `RESET_PC, o_pc);
    end
    while (retired < exp_rd.size()) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk); // stray writes would show here
    finish_run();
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    timed_out = 1'b1;
    $display("timeout after %0d cycles, %0d of %0d expected writes never retired",
             TIMEOUT_CYCLES, exp_rd.size() - retired, exp_rd.size());
    finish_run();
  end

endmodule

// File: sim.f
+incdir+.
riscv_pkg.sv
riscv_if.sv
riscv_fetch.sv
riscv_decode.sv
riscv_execute.sv
riscv_writeback.sv
riscv_core.sv
riscv_core_checker.sv
tb_riscv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_riscv_core
FILELIST  := sim.f

BIN      := obj_dir/V$(TOP)
LOG      := sim.log
FAIL_MSG := Test failed
SRCS     := $(filter-out +%,$(shell cat $(FILELIST))) riscv_macros.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
